/* design/spi_cmd_pkg.sv */
`default_nettype none

package spi_cmd_pkg;

    // one word on the spi link.
    typedef logic [15:0] spi_word_t;

    // command byte, the upper byte of the first word.
    typedef enum logic [7:0] {
        op_reg_sel     = 8'h80,
        op_mem_read    = 8'hC0,
        op_mem_write   = 8'hC1,
        op_burst_read  = 8'hD0,
        op_burst_write = 8'hD1
    } spi_opcode_e;

    // identification registers 0x00 to 0x03.
    localparam spi_word_t reg_id0 = 16'h1234;
    localparam spi_word_t reg_id1 = 16'h5678;
    localparam spi_word_t reg_id2 = 16'h9ABC;
    localparam spi_word_t reg_id3 = 16'hEF01;

    // last memory read result.
    localparam logic [7:0] reg_sel_data = 8'h04;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // data word of the memory.
    typedef logic [15:0] mem_word_t;

    // full address as the host sends it, only the low bits reach the memory.
    typedef logic [31:0] host_addr_t;

    // burst length in words.
    typedef logic [15:0] burst_len_t;

endpackage

`default_nettype wire

/* design/spi_word_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_word_slave
    import spi_cmd_pkg::*;
(
    input  logic      clk_50MHz,
    input  logic      rst_i,
    input  logic      sck_i,
    input  logic      cs_i,
    input  logic      mosi_i,
    input  spi_word_t reply_i,
    output logic      miso_o,
    output spi_word_t word_o,
    output logic      word_valid_o
);

    logic [2:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_active;
    logic [3:0] bit_cnt;
    spi_word_t  rx_shift;
    spi_word_t  tx_shift;

    // two flops per pin, the third sck flop is for edge detection.
    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], sck_i};
            cs_sync   <= {cs_sync[0], cs_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] & sck_sync[2];
    assign cs_active = ~cs_sync[1];

    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            bit_cnt      <= '0;
            tx_shift     <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            if (!cs_active) begin
                // reply for the first word is whatever is offered at cs fall.
                bit_cnt  <= '0;
                tx_shift <= reply_i;
            end else begin
                if (sck_rise) begin
                    bit_cnt      <= bit_cnt + 4'd1;
                    word_valid_o <= (bit_cnt == 4'd15);
                end
                if (sck_fall) begin
                    // count wrapped, so a word just ended.
                    if (bit_cnt == 4'd0) begin
                        tx_shift <= reply_i;
                    end else begin
                        tx_shift <= {tx_shift[14:0], 1'b0};
                    end
                end
            end
        end
    end

    // msb first on both lines.
    always_ff @(posedge clk_50MHz) begin
        if (cs_active && sck_rise) begin
            rx_shift <= {rx_shift[14:0], mosi_sync[1]};
        end
    end

    assign word_o = rx_shift;
    assign miso_o = tx_shift[15];

endmodule

`default_nettype wire

/* design/spi_cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_decoder
    import spi_cmd_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk_50MHz,
    input  logic       rst_i,
    input  spi_word_t  word_i,
    input  logic       word_valid_i,
    input  logic       busy_i,
    input  logic       word_done_i,
    input  mem_word_t  rdata_i,
    output spi_word_t  reply_o,
    output logic       start_o,
    output logic       write_o,
    output burst_len_t len_o,
    output host_addr_t addr_o,
    output logic       word_valid_o,
    output mem_word_t  wdata_o
);

    typedef enum logic [2:0] {
        st_idle,
        st_burst_len,
        st_addr_lo,
        st_addr_hi,
        st_wr_data,
        st_start,
        st_single,
        st_busy
    } cmd_state_e;

    cmd_state_e  state;
    cmd_state_e  ret_state;
    spi_opcode_e opcode;
    logic [7:0]  reg_sel;
    mem_word_t   data_reg;
    logic        single_op;

    assign opcode = spi_opcode_e'(word_i[15:8]);

    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            state        <= st_idle;
            ret_state    <= st_idle;
            reg_sel      <= '0;
            single_op    <= 1'b0;
            write_o      <= 1'b0;
            start_o      <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            start_o      <= 1'b0;
            word_valid_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (word_valid_i) begin
                        case (opcode)
                            op_reg_sel: begin
                                reg_sel <= word_i[7:0];
                            end
                            op_mem_read: begin
                                write_o   <= 1'b0;
                                single_op <= 1'b1;
                                ret_state <= st_start;
                                state     <= st_addr_lo;
                            end
                            op_mem_write: begin
                                write_o   <= 1'b1;
                                single_op <= 1'b1;
                                ret_state <= st_wr_data;
                                state     <= st_addr_lo;
                            end
                            op_burst_read: begin
                                write_o   <= 1'b0;
                                single_op <= 1'b0;
                                state     <= st_burst_len;
                            end
                            op_burst_write: begin
                                write_o   <= 1'b1;
                                single_op <= 1'b0;
                                state     <= st_burst_len;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                st_burst_len: begin
                    if (word_valid_i) begin
                        ret_state <= st_start;
                        state     <= st_addr_lo;
                    end
                end
                st_addr_lo: begin
                    if (word_valid_i) begin
                        state <= st_addr_hi;
                    end
                end
                st_addr_hi: begin
                    if (word_valid_i) begin
                        state <= ret_state;
                    end
                end
                st_wr_data: begin
                    if (word_valid_i) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (!busy_i) begin
                        start_o <= 1'b1;
                        state   <= st_single;
                    end
                end
                st_single: begin
                    // wait until the engine is busy.
                    // a single access feeds its one word itself.
                    if (busy_i) begin
                        word_valid_o <= single_op;
                        state        <= st_busy;
                    end
                end
                st_busy: begin
                    if (!busy_i) begin
                        state <= st_idle;
                    end else if (word_valid_i) begin
                        word_valid_o <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (word_valid_i) begin
            case (state)
                st_idle:      len_o          <= 16'd1;
                st_burst_len: len_o          <= word_i;
                st_addr_lo:   addr_o[15:0]   <= word_i;
                st_addr_hi:   addr_o[31:16]  <= word_i;
                st_wr_data:   wdata_o        <= word_i;
                st_busy:      wdata_o        <= word_i;
                default: begin
                end
            endcase
        end
    end

    // every finished read lands here.
    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            data_reg <= '0;
        end else if (word_done_i && !write_o) begin
            data_reg <= rdata_i;
        end
    end

    always_comb begin
        if (busy_i) begin
            reply_o = data_reg;
        end else begin
            case (reg_sel)
                8'h00:        reply_o = reg_id0;
                8'h01:        reply_o = reg_id1;
                8'h02:        reply_o = reg_id2;
                8'h03:        reply_o = reg_id3;
                reg_sel_data: reply_o = data_reg;
                default:      reply_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/mem_burst_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_burst_engine
    import mem_bus_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  logic                 clk_50MHz,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  logic                 write_i,
    input  burst_len_t           len_i,
    input  host_addr_t           addr_i,
    input  logic                 word_valid_i,
    input  mem_word_t            wdata_i,
    input  logic                 mem_ack_i,
    input  mem_word_t            mem_rdata_i,
    output logic                 busy_o,
    output logic                 word_done_o,
    output mem_word_t            rdata_o,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output logic [ADDR_BITS-1:0] mem_addr_o,
    output mem_word_t            mem_wdata_o
);

    typedef enum logic [1:0] {
        eng_idle,
        eng_wait_word,
        eng_access
    } eng_state_e;

    eng_state_e           state;
    burst_len_t           words_left;
    logic [ADDR_BITS-1:0] cur_addr;
    logic                 write_q;

    assign busy_o = (state != eng_idle);

    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            state       <= eng_idle;
            words_left  <= '0;
            cur_addr    <= '0;
            write_q     <= 1'b0;
            mem_req_o   <= 1'b0;
            mem_we_o    <= 1'b0;
            word_done_o <= 1'b0;
        end else begin
            mem_req_o   <= 1'b0;
            word_done_o <= 1'b0;
            case (state)
                eng_idle: begin
                    if (start_i) begin
                        write_q    <= write_i;
                        cur_addr   <= addr_i[ADDR_BITS-1:0];
                        // zero length behaves as one word.
                        words_left <= (len_i == '0) ? 16'd1 : len_i;
                        state      <= eng_wait_word;
                    end
                end
                eng_wait_word: begin
                    if (word_valid_i) begin
                        mem_req_o  <= 1'b1;
                        mem_we_o   <= write_q;
                        cur_addr   <= cur_addr + ADDR_BITS'(1);
                        words_left <= words_left - 16'd1;
                        state      <= eng_access;
                    end
                end
                eng_access: begin
                    if (mem_ack_i) begin
                        word_done_o <= 1'b1;
                        state       <= (words_left == '0) ? eng_idle : eng_wait_word;
                    end
                end
                default: begin
                    state <= eng_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (state == eng_wait_word && word_valid_i) begin
            mem_addr_o  <= cur_addr;
            mem_wdata_o <= wdata_i;
        end
        if (state == eng_access && mem_ack_i) begin
            rdata_o <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* design/word_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module word_ram
    import mem_bus_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  logic                 clk_50MHz,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  logic [ADDR_BITS-1:0] addr_i,
    input  mem_word_t            wdata_i,
    output logic                 ack_o,
    output mem_word_t            rdata_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    mem_word_t mem [0:DEPTH-1];

    always_ff @(posedge clk_50MHz) begin
        if (req_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

    // ack one cycle after each request.
    always_ff @(posedge clk_50MHz or posedge rst_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

endmodule

`default_nettype wire

/* design/spi_mem_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_mem_bridge
    import spi_cmd_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  logic clk_50MHz,
    input  logic rst_i,
    input  logic spi_sck_i,
    input  logic spi_cs_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    spi_word_t            reply;
    spi_word_t            rx_word;
    logic                 rx_valid;
    logic                 start;
    logic                 write;
    burst_len_t           len;
    host_addr_t           addr;
    logic                 cmd_word_valid;
    mem_word_t            wdata;
    logic                 busy;
    logic                 word_done;
    mem_word_t            rdata;
    logic                 mem_req;
    logic                 mem_we;
    logic [ADDR_BITS-1:0] mem_addr;
    mem_word_t            mem_wdata;
    logic                 mem_ack;
    mem_word_t            mem_rdata;

    spi_word_slave u_slave (
        .clk_50MHz    (clk_50MHz),
        .rst_i        (rst_i),
        .sck_i        (spi_sck_i),
        .cs_i         (spi_cs_i),
        .mosi_i       (spi_mosi_i),
        .reply_i      (reply),
        .miso_o       (spi_miso_o),
        .word_o       (rx_word),
        .word_valid_o (rx_valid)
    );

    spi_cmd_decoder u_decoder (
        .clk_50MHz    (clk_50MHz),
        .rst_i        (rst_i),
        .word_i       (rx_word),
        .word_valid_i (rx_valid),
        .busy_i       (busy),
        .word_done_i  (word_done),
        .rdata_i      (rdata),
        .reply_o      (reply),
        .start_o      (start),
        .write_o      (write),
        .len_o        (len),
        .addr_o       (addr),
        .word_valid_o (cmd_word_valid),
        .wdata_o      (wdata)
    );

    mem_burst_engine #(
        .ADDR_BITS (ADDR_BITS)
    ) u_engine (
        .clk_50MHz    (clk_50MHz),
        .rst_i        (rst_i),
        .start_i      (start),
        .write_i      (write),
        .len_i        (len),
        .addr_i       (addr),
        .word_valid_i (cmd_word_valid),
        .wdata_i      (wdata),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata),
        .busy_o       (busy),
        .word_done_o  (word_done),
        .rdata_o      (rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata)
    );

    word_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) u_ram (
        .clk_50MHz (clk_50MHz),
        .rst_i     (rst_i),
        .req_i     (mem_req),
        .we_i      (mem_we),
        .addr_i    (mem_addr),
        .wdata_i   (mem_wdata),
        .ack_o     (mem_ack),
        .rdata_o   (mem_rdata)
    );

endmodule

`default_nettype wire

/* verif/spi_mem_bridge_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_mem_bridge_chk (
    input logic clk_50MHz,
    input logic rst_i,
    input logic start_i,
    input logic busy_i,
    input logic word_valid_i,
    input logic word_done_i,
    input logic mem_req_i,
    input logic mem_ack_i
);

    // memory answers exactly one cycle after each request.
    ack_follows_req: assert property (
        @(posedge clk_50MHz) disable iff (rst_i)
        mem_ack_i == $past(mem_req_i)
    ) else $error("mem_ack_i does not follow mem_req_o by one cycle");

    // request, acknowledge, then done.
    done_after_word: assert property (
        @(posedge clk_50MHz) disable iff (rst_i)
        word_done_i == $past(word_valid_i && busy_i, 3)
    ) else $error("word_done_o not 3 cycles after word_valid_i");

    start_when_idle: assert property (
        @(posedge clk_50MHz) disable iff (rst_i)
        start_i |-> !busy_i
    ) else $error("start_i arrived while busy_o was high");

endmodule

bind mem_burst_engine spi_mem_bridge_chk u_chk (
    .clk_50MHz    (clk_50MHz),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .busy_i       (busy_o),
    .word_valid_i (word_valid_i),
    .word_done_i  (word_done_o),
    .mem_req_i    (mem_req_o),
    .mem_ack_i    (mem_ack_i)
);

`default_nettype wire

/* verif/spi_mem_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_mem_bridge_tb
    import spi_cmd_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int ADDR_BITS  = 10;
    localparam int DEPTH      = 2 ** ADDR_BITS;
    localparam int HALF_CLKS  = 10;
    localparam int IDLE_LIMIT = 2000;
    localparam int BURST_LEN  = 8;

    logic clk_50MHz = 1'b0;
    logic rst_i;
    logic spi_sck;
    logic spi_cs;
    logic spi_mosi;
    logic spi_miso;

    logic [31:0] lfsr_state = 32'h71bb_a20e;

    // expected memory contents, filled as words are written.
    mem_word_t ref_mem [0:DEPTH-1];

    spi_mem_bridge #(
        .ADDR_BITS (ADDR_BITS)
    ) uut (
        .clk_50MHz  (clk_50MHz),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int mem_index(input host_addr_t addr);
        return int'(addr[ADDR_BITS-1:0]);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_mem(input string name, input mem_word_t got, input mem_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic pause_clocks(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk_50MHz);
        end
    endtask

    task automatic wait_engine_idle(input string where);
        int cnt;
        cnt = 0;
        while (uut.busy !== 1'b0 && cnt < IDLE_LIMIT) begin
            @(posedge clk_50MHz);
            cnt++;
        end
        if (cnt >= IDLE_LIMIT) begin
            fail_run({"burst engine stayed busy too long in ", where});
        end
    endtask

    task automatic cs_begin();
        @(posedge clk_50MHz);
        wait_engine_idle("cs_begin");
        spi_cs <= 1'b0;
        pause_clocks(HALF_CLKS);
    endtask

    task automatic cs_end();
        pause_clocks(4);
        wait_engine_idle("cs_end");
        spi_cs <= 1'b1;
        pause_clocks(HALF_CLKS);
    endtask

    // mode 0, miso is taken just before each rising sck.
    task automatic spi_xfer(input spi_word_t tx, output spi_word_t rx);
        int i;
        @(posedge clk_50MHz);
        for (i = 15; i >= 0; i--) begin
            spi_mosi <= tx[i];
            pause_clocks(HALF_CLKS);
            rx[i] = spi_miso;
            spi_sck <= 1'b1;
            pause_clocks(HALF_CLKS);
            spi_sck <= 1'b0;
        end
    endtask

    task automatic send_addr(input host_addr_t addr);
        spi_word_t discard;
        spi_xfer(addr[15:0], discard);
        spi_xfer(addr[31:16], discard);
    endtask

    task automatic reg_read(input logic [7:0] sel, output spi_word_t val);
        spi_word_t discard;
        cs_begin();
        spi_xfer({op_reg_sel, sel}, discard);
        spi_xfer(16'h0000, val);
        cs_end();
    endtask

    task automatic write_single(input host_addr_t addr, input mem_word_t data);
        spi_word_t discard;
        cs_begin();
        spi_xfer({op_mem_write, 8'h00}, discard);
        send_addr(addr);
        spi_xfer(data, discard);
        cs_end();
        ref_mem[mem_index(addr)] = data;
    endtask

    // the word lands in register 0x04 and is read back from there.
    task automatic read_single(input host_addr_t addr, input string name);
        spi_word_t discard;
        spi_word_t val;
        cs_begin();
        spi_xfer({op_mem_read, 8'h00}, discard);
        send_addr(addr);
        cs_end();
        reg_read(reg_sel_data, val);
        check_mem(name, val, ref_mem[mem_index(addr)]);
    endtask

    task automatic write_burst(input host_addr_t addr, input int count);
        spi_word_t discard;
        mem_word_t data;
        int        k;
        cs_begin();
        spi_xfer({op_burst_write, 8'h00}, discard);
        spi_xfer(burst_len_t'(count), discard);
        send_addr(addr);
        for (k = 0; k < count; k++) begin
            data = mem_word_t'(rand_bits(16));
            ref_mem[mem_index(addr + host_addr_t'(k))] = data;
            spi_xfer(data, discard);
        end
        cs_end();
    endtask

    task automatic read_burst(input host_addr_t addr, input int count);
        spi_word_t discard;
        spi_word_t val;
        int        k;
        cs_begin();
        spi_xfer({op_burst_read, 8'h00}, discard);
        spi_xfer(burst_len_t'(count), discard);
        send_addr(addr);
        for (k = 0; k < count; k++) begin
            spi_xfer(16'h0000, val);
            // each reply carries the word read for the previous host word.
            if (k > 0) begin
                check_mem("spi_miso_o burst word", val,
                          ref_mem[mem_index(addr + host_addr_t'(k - 1))]);
            end
        end
        cs_end();
        reg_read(reg_sel_data, val);
        check_mem("spi_miso_o burst last word", val,
                  ref_mem[mem_index(addr + host_addr_t'(count - 1))]);
    endtask

    task automatic after_reset_reply();
        spi_word_t val;
        cs_begin();
        spi_xfer(16'h0000, val);
        cs_end();
        check_word("spi_miso_o after reset", val, reg_id0);
    endtask

    task automatic register_select();
        spi_word_t ids [4];
        spi_word_t val;
        int        k;
        ids = '{reg_id0, reg_id1, reg_id2, reg_id3};
        for (k = 0; k < 4; k++) begin
            reg_read(8'(k), val);
            check_word($sformatf("spi_miso_o reg 0x%02h", k), val, ids[k]);
        end
        reg_read(8'h07, val);
        check_word("spi_miso_o reg 0x07", val, 16'h0000);
    endtask

    task automatic single_access();
        host_addr_t addr;
        host_addr_t other;
        host_addr_t alias_addr;
        mem_word_t  data;
        addr       = rand_bits(32);
        data       = mem_word_t'(rand_bits(16));
        other      = addr ^ 32'h0000_0001;
        alias_addr = addr ^ (32'h1 << ADDR_BITS) ^ 32'h8000_0000;
        write_single(addr, data);
        write_single(other, ~data);
        read_single(addr, "data register");
        read_single(other, "data register neighbour");
        read_single(alias_addr, "data register alias");
    endtask

    task automatic burst_access();
        host_addr_t addr;
        addr = rand_bits(32);
        write_burst(addr, BURST_LEN);
        read_burst(addr, BURST_LEN);
    endtask

    task automatic unknown_opcode();
        spi_word_t discard;
        spi_word_t val;
        cs_begin();
        spi_xfer(16'hA500, discard);
        spi_xfer({op_reg_sel, 8'h01}, discard);
        spi_xfer(16'h0000, val);
        cs_end();
        check_word("spi_miso_o after unknown opcode", val, reg_id1);
    endtask

    initial begin
        rst_i    <= 1'b1;
        spi_sck  <= 1'b0;
        spi_cs   <= 1'b1;
        spi_mosi <= 1'b0;
        pause_clocks(3);
        rst_i <= 1'b0;
        pause_clocks(5);

        after_reset_reply();
        register_select();
        single_access();
        burst_access();
        unknown_opcode();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* spi_mem_bridge.f */
design/spi_cmd_pkg.sv
design/mem_bus_pkg.sv
design/spi_word_slave.sv
design/spi_cmd_decoder.sv
design/mem_burst_engine.sv
design/word_ram.sv
design/spi_mem_bridge.sv
verif/spi_mem_bridge_chk.sv
verif/spi_mem_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the spi_mem_bridge testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log
fail_msg="ERRORS FOUND"
pass_msg="NO ERRORS"

mkdir -p "$build_dir"
if [ $? -ne 0 ]; then
    echo "could not create $build_dir"
    exit 1
fi

verilator --binary --timing --assert \
    -f spi_mem_bridge.f \
    --top-module spi_mem_bridge_tb \
    -Mdir "$build_dir" -o Vspi_mem_bridge_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"$build_dir/Vspi_mem_bridge_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "$fail_msg" "$log_file"; then
    echo "simulation failed, see $log_file"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "$pass_msg" "$log_file"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0
